// ==== logic/mem_io_pkg.sv ====
`default_nettype none

package mem_io_pkg;

    // Data path widths
    localparam int DATA_W     = 32;
    localparam int LANES      = 4;
    localparam int LANE_W     = 8;
    localparam int WORD_IDX_W = 14;  // 16K words, 64 KiB of data memory

    // I/O page sits at the top 1 KiB of the address space
    localparam logic [21:0] IO_PAGE = 22'h3F_FFFF;
    localparam logic [9:0]  LED_OFS = 10'h060;  // LED register, two halfwords
    localparam logic [9:0]  SW_OFS  = 10'h070;  // Switch register, two halfwords

    localparam int LED_W = 24;
    localparam int SW_W  = 24;

    // Access width codes as driven by the memory stage
    localparam logic [1:0] WIDTH_BYTE = 2'd0;
    localparam logic [1:0] WIDTH_HALF = 2'd1;
    localparam logic [1:0] WIDTH_WORD = 2'd2;

    // One address word, read either as a RAM location or as an I/O register
    typedef union packed {
        struct packed {
            logic [DATA_W-WORD_IDX_W-3:0] unused;    // Aliased away
            logic [WORD_IDX_W-1:0]        word_idx;
            logic [1:0]                   byte_ofs;
        } mem;
        struct packed {
            logic [21:0] page;  // Compared against IO_PAGE
            logic [9:0]  ofs;
        } io;
    } mem_io_addr_u;

endpackage

`default_nettype wire

// ==== logic/access_decode.sv ====
`default_nettype none

module access_decode (
    input  wire                                   fpga_clk,
    input  wire                                   fpga_rst,
    input  wire                                   read_i,
    input  wire                                   write_i,
    input  wire  [mem_io_pkg::DATA_W-1:0]         addr_i,
    input  wire  [1:0]                            width_i,
    input  wire                                   sign_i,
    input  wire  [mem_io_pkg::DATA_W-1:0]         wdata_i,
    output logic [mem_io_pkg::LANES-1:0]          lane_we_o,
    output logic                                  lane_re_o,
    output logic [mem_io_pkg::WORD_IDX_W-1:0]     word_idx_o,
    output logic [mem_io_pkg::DATA_W-1:0]         lane_wdata_o,
    output logic                                  led_wr_o,
    output logic                                  sw_rd_o,
    output logic                                  io_hsel_o,
    output logic [mem_io_pkg::DATA_W/2-1:0]       io_wdata_o,
    output logic                                  tag_valid_o,
    output logic                                  tag_io_o,
    output logic [1:0]                            tag_offset_o,
    output logic [1:0]                            tag_width_o,
    output logic                                  tag_sign_o
);
    import mem_io_pkg::*;

    mem_io_addr_u     addr;
    logic             is_io;
    logic             led_hit;
    logic             sw_hit;
    logic [LANES-1:0] lane_mask;

    assign addr  = addr_i;
    assign is_io = (addr.io.page == IO_PAGE);

    // Register offset bits 1:0 pick the halfword, not the register
    assign led_hit = is_io && (addr.io.ofs[9:2] == LED_OFS[9:2]);
    assign sw_hit  = is_io && (addr.io.ofs[9:2] == SW_OFS[9:2]);

    // Lane enables and store data placed in lane position
    always_comb begin
        case (width_i)
            WIDTH_BYTE: begin
                lane_mask    = {{(LANES-1){1'b0}}, 1'b1} << addr.mem.byte_ofs;
                lane_wdata_o = {LANES{wdata_i[LANE_W-1:0]}};
            end
            WIDTH_HALF: begin
                lane_mask    = addr.mem.byte_ofs[1] ? 4'b1100 : 4'b0011;
                lane_wdata_o = {2{wdata_i[2*LANE_W-1:0]}};
            end
            default: begin  // Word, and the unused code 3
                lane_mask    = '1;
                lane_wdata_o = wdata_i;
            end
        endcase
    end

    assign lane_we_o  = (write_i && !is_io) ? lane_mask : '0;
    assign lane_re_o  = read_i && !is_io;
    assign word_idx_o = addr.mem.word_idx;

    assign led_wr_o   = write_i && led_hit;
    assign sw_rd_o    = read_i && sw_hit;  // Unmapped offsets strobe nothing
    assign io_hsel_o  = addr.io.ofs[1];
    assign io_wdata_o = wdata_i[DATA_W/2-1:0];

    // Load tag follows the RAM read by one cycle
    always_ff @(posedge fpga_clk) begin
        if (fpga_rst) begin
            tag_valid_o <= 1'b0;
        end else begin
            tag_valid_o <= read_i;
        end
        if (read_i) begin
            tag_io_o     <= is_io;
            tag_offset_o <= addr.mem.byte_ofs;
            tag_width_o  <= width_i;
            tag_sign_o   <= sign_i;
        end
    end

endmodule

`default_nettype wire

// ==== logic/byte_lane_ram.sv ====
`default_nettype none

module byte_lane_ram (
    input  wire                                fpga_clk,
    input  wire                                we_i,
    input  wire                                re_i,
    input  wire  [mem_io_pkg::WORD_IDX_W-1:0]  idx_i,
    input  wire  [mem_io_pkg::LANE_W-1:0]      wdata_i,
    output logic [mem_io_pkg::LANE_W-1:0]      rdata_o
);
    import mem_io_pkg::*;

    localparam int DEPTH = 1 << WORD_IDX_W;

    logic [LANE_W-1:0] mem [DEPTH];

    // Write and read never meet in one cycle, strobes are exclusive
    always_ff @(posedge fpga_clk) begin
        if (we_i) begin
            mem[idx_i] <= wdata_i;
        end
        if (re_i) begin
            rdata_o <= mem[idx_i];  // Held until the next read
        end
    end

endmodule

`default_nettype wire

// ==== logic/load_align.sv ====
`default_nettype none

module load_align (
    input  wire                            tag_valid_i,
    input  wire                            tag_io_i,
    input  wire  [1:0]                     tag_offset_i,
    input  wire  [1:0]                     tag_width_i,
    input  wire                            tag_sign_i,
    input  wire  [mem_io_pkg::DATA_W-1:0]  lane_rdata_i,
    input  wire  [mem_io_pkg::DATA_W-1:0]  sw_rdata_i,
    output logic [mem_io_pkg::DATA_W-1:0]  rdata_o,
    output logic                           rdata_valid_o
);
    import mem_io_pkg::*;

    logic [DATA_W-1:0] word;
    logic [1:0]        ofs;
    logic [DATA_W-1:0] shifted;
    logic [DATA_W-1:0] ext;

    // Lane 0 is the low byte of the word
    assign word = tag_io_i ? sw_rdata_i : lane_rdata_i;

    always_comb begin
        case (tag_width_i)
            WIDTH_BYTE: ofs = tag_offset_i;
            WIDTH_HALF: ofs = {tag_offset_i[1], 1'b0};  // Bit 0 ignored
            default:    ofs = 2'b00;
        endcase
    end

    assign shifted = word >> {ofs, 3'b000};

    // Sign bit copied only for signed loads
    always_comb begin
        case (tag_width_i)
            WIDTH_BYTE: begin
                ext = {{(DATA_W-LANE_W){tag_sign_i & shifted[LANE_W-1]}},
                       shifted[LANE_W-1:0]};
            end
            WIDTH_HALF: begin
                ext = {{(DATA_W-2*LANE_W){tag_sign_i & shifted[2*LANE_W-1]}},
                       shifted[2*LANE_W-1:0]};
            end
            default: begin
                ext = shifted;
            end
        endcase
    end

    assign rdata_o       = tag_valid_i ? ext : '0;
    assign rdata_valid_o = tag_valid_i;

endmodule

`default_nettype wire

// ==== logic/io_ports.sv ====
`default_nettype none

module io_ports (
    input  wire                               fpga_clk,
    input  wire                               fpga_rst,
    input  wire                               led_wr_i,
    input  wire                               sw_rd_i,
    input  wire                               hsel_i,
    input  wire  [mem_io_pkg::DATA_W/2-1:0]   wdata_i,
    input  wire  [mem_io_pkg::SW_W-1:0]       switch_i,
    output logic [mem_io_pkg::LED_W-1:0]      led_o,
    output logic [mem_io_pkg::DATA_W-1:0]     sw_rdata_o
);
    import mem_io_pkg::*;

    localparam int HALF_W = DATA_W / 2;

    logic [DATA_W-1:0] sw_sample;

    // LED register, low halfword or the upper byte
    always_ff @(posedge fpga_clk) begin
        if (fpga_rst) begin
            led_o <= '0;
        end else if (led_wr_i) begin
            if (hsel_i) begin
                led_o[LED_W-1:HALF_W] <= wdata_i[LED_W-HALF_W-1:0];
            end else begin
                led_o[HALF_W-1:0] <= wdata_i;
            end
        end
    end

    // Sample sits in the halfword lane its address selects,
    // so load_align treats it like RAM data
    always_comb begin
        if (hsel_i) begin
            sw_sample = {{(DATA_W-SW_W){1'b0}}, switch_i[SW_W-1:HALF_W], {HALF_W{1'b0}}};
        end else begin
            sw_sample = {{HALF_W{1'b0}}, switch_i[HALF_W-1:0]};
        end
    end

    // Cleared when not selected, unmapped I/O reads then return zero
    always_ff @(posedge fpga_clk) begin
        if (sw_rd_i) begin
            sw_rdata_o <= sw_sample;
        end else begin
            sw_rdata_o <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/mem_io_top.sv ====
`default_nettype none

module mem_io_top (
    input  wire                               fpga_clk,
    input  wire                               fpga_rst,
    input  wire                               read_i,
    input  wire                               write_i,
    input  wire  [mem_io_pkg::DATA_W-1:0]     addr_i,
    input  wire  [1:0]                        width_i,
    input  wire                               sign_i,
    input  wire  [mem_io_pkg::DATA_W-1:0]     wdata_i,
    input  wire  [mem_io_pkg::SW_W-1:0]       switch_i,
    output logic [mem_io_pkg::DATA_W-1:0]     rdata_o,
    output logic                              rdata_valid_o,
    output logic [mem_io_pkg::LED_W-1:0]      led_o
);
    import mem_io_pkg::*;

    // Decode to RAM lanes
    logic [LANES-1:0]      lane_we;
    logic                  lane_re;
    logic [WORD_IDX_W-1:0] word_idx;
    logic [DATA_W-1:0]     lane_wdata;
    logic [DATA_W-1:0]     lane_rdata;

    // Decode to I/O
    logic                  led_wr;
    logic                  sw_rd;
    logic                  io_hsel;
    logic [DATA_W/2-1:0]   io_wdata;
    logic [DATA_W-1:0]     sw_rdata;

    // Load tag, one cycle behind the strobe
    logic                  tag_valid;
    logic                  tag_io;
    logic [1:0]            tag_offset;
    logic [1:0]            tag_width;
    logic                  tag_sign;

    access_decode u_decode (
        .fpga_clk     (fpga_clk),
        .fpga_rst     (fpga_rst),
        .read_i       (read_i),
        .write_i      (write_i),
        .addr_i       (addr_i),
        .width_i      (width_i),
        .sign_i       (sign_i),
        .wdata_i      (wdata_i),
        .lane_we_o    (lane_we),
        .lane_re_o    (lane_re),
        .word_idx_o   (word_idx),
        .lane_wdata_o (lane_wdata),
        .led_wr_o     (led_wr),
        .sw_rd_o      (sw_rd),
        .io_hsel_o    (io_hsel),
        .io_wdata_o   (io_wdata),
        .tag_valid_o  (tag_valid),
        .tag_io_o     (tag_io),
        .tag_offset_o (tag_offset),
        .tag_width_o  (tag_width),
        .tag_sign_o   (tag_sign)
    );

    for (genvar k = 0; k < LANES; k++) begin : g_lane
        byte_lane_ram u_lane (
            .fpga_clk (fpga_clk),
            .we_i     (lane_we[k]),
            .re_i     (lane_re),
            .idx_i    (word_idx),
            .wdata_i  (lane_wdata[k*LANE_W +: LANE_W]),
            .rdata_o  (lane_rdata[k*LANE_W +: LANE_W])
        );
    end

    load_align u_align (
        .tag_valid_i   (tag_valid),
        .tag_io_i      (tag_io),
        .tag_offset_i  (tag_offset),
        .tag_width_i   (tag_width),
        .tag_sign_i    (tag_sign),
        .lane_rdata_i  (lane_rdata),
        .sw_rdata_i    (sw_rdata),
        .rdata_o       (rdata_o),
        .rdata_valid_o (rdata_valid_o)
    );

    io_ports u_io (
        .fpga_clk   (fpga_clk),
        .fpga_rst   (fpga_rst),
        .led_wr_i   (led_wr),
        .sw_rd_i    (sw_rd),
        .hsel_i     (io_hsel),
        .wdata_i    (io_wdata),
        .switch_i   (switch_i),
        .led_o      (led_o),
        .sw_rdata_o (sw_rdata)
    );

endmodule

`default_nettype wire

// ==== verif/mem_io_chk.sv ====
`default_nettype none

module mem_io_chk (
    input wire                           fpga_clk,
    input wire                           fpga_rst,
    input wire                           read_i,
    input wire                           write_i,
    input wire                           rdata_valid_i,
    input wire [mem_io_pkg::LANES-1:0]   lane_we_i
);
    int fail_count = 0;

    // Memory stage issues one access per cycle at most
    a_strobe_excl: assert property (@(posedge fpga_clk) disable iff (fpga_rst)
        !(read_i && write_i))
        else begin
            fail_count++;
            $error("read_i and write_i high in the same cycle");
        end

    a_valid_after_read: assert property (@(posedge fpga_clk) disable iff (fpga_rst)
        read_i |=> rdata_valid_i)
        else begin
            fail_count++;
            $error("rdata_valid_o missing one cycle after read_i");
        end

    a_no_valid_without_read: assert property (@(posedge fpga_clk) disable iff (fpga_rst)
        !read_i |=> !rdata_valid_i)
        else begin
            fail_count++;
            $error("rdata_valid_o high without a read one cycle earlier");
        end

    // Lane enables only ever come from a store
    a_lane_we_needs_write: assert property (@(posedge fpga_clk) disable iff (fpga_rst)
        (|lane_we_i) |-> write_i)
        else begin
            fail_count++;
            $error("Lane write enable set without write_i");
        end

endmodule

bind mem_io_top mem_io_chk u_chk (
    .fpga_clk      (fpga_clk),
    .fpga_rst      (fpga_rst),
    .read_i        (read_i),
    .write_i       (write_i),
    .rdata_valid_i (rdata_valid_o),
    .lane_we_i     (lane_we)
);

`default_nettype wire

// ==== verif/mem_io_tb.sv ====
`default_nettype none

module mem_io_tb;
    import mem_io_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int N_FILL = 16384;
    localparam int N_WORD = 200;
    localparam int N_SUB  = 100;
    localparam int N_EXT  = 16;
    localparam int N_RUN  = 24;
    localparam int N_IO   = 40;
    localparam int TOTAL_CYCLES = 10 + 4 + N_FILL + 2*N_WORD + 2*N_SUB + 9*N_EXT
                                + 9*N_RUN + 5*N_IO + 20;
    localparam int WATCHDOG_T = (TOTAL_CYCLES + 200) * CLK_PERIOD;

    logic        fpga_clk;
    logic        fpga_rst;
    logic        read_i;
    logic        write_i;
    logic [31:0] addr_i;
    logic [1:0]  width_i;
    logic        sign_i;
    logic [31:0] wdata_i;
    logic [23:0] switch_i;
    logic [31:0] rdata_o;
    logic        rdata_valid_o;
    logic [23:0] led_o;

    // Reference model state
    logic [7:0]  mem_model [0:65535];
    logic [23:0] led_model;
    logic [23:0] sw_model;
    logic [31:0] exp_q [$];
    logic [31:0] lfsr;
    logic [13:0] t1_idx [N_WORD];
    string       test_name;
    int          errors;
    int          checks;

    mem_io_top dut0 (
        .fpga_clk      (fpga_clk),
        .fpga_rst      (fpga_rst),
        .read_i        (read_i),
        .write_i       (write_i),
        .addr_i        (addr_i),
        .width_i       (width_i),
        .sign_i        (sign_i),
        .wdata_i       (wdata_i),
        .switch_i      (switch_i),
        .rdata_o       (rdata_o),
        .rdata_valid_o (rdata_valid_o),
        .led_o         (led_o)
    );

    initial begin
        fpga_clk = 1'b0;
        forever #(CLK_PERIOD/2) fpga_clk = ~fpga_clk;
    end

    // Taps 32, 22, 2 and 1 with one step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [1:0] rand_width();
        logic [31:0] r;
        r = take_bits(2);
        if (r[1:0] == 2'd3) begin
            return WIDTH_WORD;
        end
        return r[1:0];
    endfunction

    // Random alias bits above the index with bit 31 low to stay out of I/O
    function automatic logic [31:0] mem_addr(input logic [13:0] idx, input logic [1:0] ofs);
        logic [31:0] hi;
        hi = take_bits(15);
        return {1'b0, hi[14:0], idx, ofs};
    endfunction

    function automatic logic [31:0] model_word(input logic [13:0] idx);
        return {mem_model[{idx, 2'd3}], mem_model[{idx, 2'd2}],
                mem_model[{idx, 2'd1}], mem_model[{idx, 2'd0}]};
    endfunction

    function automatic logic [31:0] expect_read(input logic [31:0] addr,
                                                input logic [1:0] width, input logic sign);
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        if (addr[31:10] == IO_PAGE) begin
            if (addr[9:2] == SW_OFS[9:2]) begin
                w = addr[1] ? {8'h00, sw_model[23:16], 16'h0000} : {16'h0000, sw_model[15:0]};
            end else begin
                w = '0;  // Unmapped I/O
            end
        end else begin
            w = model_word(addr[15:2]);
        end
        case (addr[1:0])
            2'd0: b = w[7:0];
            2'd1: b = w[15:8];
            2'd2: b = w[23:16];
            default: b = w[31:24];
        endcase
        h = addr[1] ? w[31:16] : w[15:0];
        if (width == WIDTH_BYTE) begin
            return sign ? {{24{b[7]}}, b} : {24'h000000, b};
        end else if (width == WIDTH_HALF) begin
            return sign ? {{16{h[15]}}, h} : {16'h0000, h};
        end
        return w;
    endfunction

    task automatic store_model(input logic [31:0] addr, input logic [1:0] width,
                               input logic [31:0] wdata);
        if (addr[31:10] == IO_PAGE) begin
            if (addr[9:2] == LED_OFS[9:2]) begin
                if (addr[1]) begin
                    led_model[23:16] = wdata[7:0];
                end else begin
                    led_model[15:0] = wdata[15:0];
                end
            end
        end else if (width == WIDTH_BYTE) begin
            mem_model[addr[15:0]] = wdata[7:0];
        end else if (width == WIDTH_HALF) begin
            mem_model[{addr[15:2], addr[1], 1'b0}] = wdata[7:0];
            mem_model[{addr[15:2], addr[1], 1'b1}] = wdata[15:8];
        end else begin
            mem_model[{addr[15:2], 2'd0}] = wdata[7:0];
            mem_model[{addr[15:2], 2'd1}] = wdata[15:8];
            mem_model[{addr[15:2], 2'd2}] = wdata[23:16];
            mem_model[{addr[15:2], 2'd3}] = wdata[31:24];
        end
    endtask

    task automatic check_response();
        logic [31:0] exp;
        if (rdata_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected rdata_valid_o pulse with no read issued in %s", test_name);
            end else begin
                exp = exp_q.pop_front();
                checks++;
                if (rdata_o !== exp) begin
                    errors++;
                    $display("Error %s: expected %h, actual %h", test_name, exp, rdata_o);
                end
            end
        end else begin
            checks++;
            if (rdata_o !== 32'h0000_0000) begin  // Idle data must read as zero
                errors++;
                $display("Error %s (idle rdata_o): expected %h, actual %h",
                         test_name, 32'h0000_0000, rdata_o);
            end
            if (exp_q.size() != 0) begin
                exp = exp_q.pop_front();
                errors++;
                $display("No rdata_valid_o pulse one cycle after a read in %s", test_name);
            end
        end
        checks++;
        if (led_o !== led_model) begin
            errors++;
            $display("Error %s (led_o): expected %h, actual %h", test_name, led_model, led_o);
        end
    endtask

    // Wait for the falling edge, check the outputs and drop the strobes
    task automatic step();
        @(negedge fpga_clk);
        check_response();
        read_i  = 1'b0;
        write_i = 1'b0;
    endtask

    task automatic do_write(input logic [31:0] addr, input logic [1:0] width,
                            input logic [31:0] wdata);
        store_model(addr, width, wdata);
        addr_i  = addr;
        width_i = width;
        wdata_i = wdata;
        sign_i  = 1'b0;
        write_i = 1'b1;
        step();
    endtask

    task automatic do_read(input logic [31:0] addr, input logic [1:0] width, input logic sign);
        exp_q.push_back(expect_read(addr, width, sign));
        addr_i  = addr;
        width_i = width;
        sign_i  = sign;
        read_i  = 1'b1;
        step();
    endtask

    initial begin
        #(WATCHDOG_T);
        $display("Watchdog expired after %0d cycles, the run did not finish", TOTAL_CYCLES + 200);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] s;
        logic [9:0]  ofs;
        int          len;
        fpga_rst  = 1'b1;
        read_i    = 1'b0;
        write_i   = 1'b0;
        addr_i    = '0;
        width_i   = WIDTH_WORD;
        sign_i    = 1'b0;
        wdata_i   = '0;
        switch_i  = '0;
        led_model = '0;
        sw_model  = '0;
        lfsr      = 32'h4cd56743;
        errors    = 0;
        checks    = 0;

        repeat (10) @(posedge fpga_clk);
        @(negedge fpga_clk);
        fpga_rst  = 1'b0;
        test_name = "reset";
        repeat (4) step();

        // Fill pattern carries the whole word index twice
        test_name = "fill";
        for (int i = 0; i < N_FILL; i++) begin
            do_write(mem_addr(i[13:0], 2'b00), WIDTH_WORD, {2'b10, i[13:0], 2'b01, i[13:0]});
        end

        test_name = "word_round_trip";
        for (int i = 0; i < N_WORD; i++) begin
            r = take_bits(14);
            t1_idx[i] = r[13:0];
            do_write(mem_addr(r[13:0], 2'b00), WIDTH_WORD, take_bits(32));
        end
        for (int i = 0; i < N_WORD; i++) begin
            do_read(mem_addr(t1_idx[i], 2'b00), WIDTH_WORD, 1'b0);
        end

        test_name = "partial_store";
        for (int i = 0; i < N_SUB; i++) begin
            r = take_bits(7);
            s = take_bits(32);
            do_write(mem_addr({10'h010, r[3:0]}, r[5:4]), r[6] ? WIDTH_HALF : WIDTH_BYTE, s);
            do_read(mem_addr({10'h010, r[3:0]}, 2'b00), WIDTH_WORD, 1'b0);
        end

        test_name = "extension";
        for (int i = 0; i < N_EXT; i++) begin
            do_write(mem_addr({10'h010, i[3:0]}, 2'b00), WIDTH_WORD, take_bits(32));
            for (int o = 0; o < 4; o++) begin
                r = take_bits(1);
                do_read(mem_addr({10'h010, i[3:0]}, o[1:0]), WIDTH_BYTE, r[0]);
            end
            for (int o = 0; o < 4; o++) begin
                r = take_bits(1);
                do_read(mem_addr({10'h010, i[3:0]}, o[1:0]), WIDTH_HALF, r[0]);
            end
        end

        test_name = "back_to_back";
        for (int i = 0; i < N_RUN; i++) begin
            r   = take_bits(3);
            len = int'(r[2:0]) + 1;
            for (int j = 0; j < len; j++) begin
                r = take_bits(7);
                do_read(mem_addr({10'h010, r[3:0]}, r[5:4]), rand_width(), r[6]);
            end
            step();
        end

        test_name = "led_switch_io";
        for (int i = 0; i < N_IO; i++) begin
            s = take_bits(32);
            do_write({IO_PAGE, LED_OFS[9:2], s[31], 1'b0}, WIDTH_HALF, s);
            r = take_bits(24);
            sw_model = r[23:0];
            switch_i = sw_model;
            r = take_bits(3);
            do_read({IO_PAGE, SW_OFS[9:2], r[1:0]}, rand_width(), r[2]);
            r   = take_bits(10);
            ofs = {1'b1, r[8:0]};  // Bit 9 set is outside both registers
            do_read({IO_PAGE, ofs}, rand_width(), r[9]);
            do_write({IO_PAGE, ofs}, WIDTH_WORD, take_bits(32));
            do_read(mem_addr({6'h3F, ofs[9:2]}, 2'b00), WIDTH_WORD, 1'b0);
        end

        test_name = "reset_again";
        fpga_rst  = 1'b1;
        led_model = '0;
        repeat (10) step();
        fpga_rst = 1'b0;
        repeat (3) step();
        do_read(mem_addr(14'h0100, 2'b00), WIDTH_WORD, 1'b0);
        step();

        errors += dut0.u_chk.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
logic/mem_io_pkg.sv
logic/access_decode.sv
logic/byte_lane_ram.sv
logic/load_align.sv
logic/io_ports.sv
logic/mem_io_top.sv
verif/mem_io_chk.sv
verif/mem_io_tb.sv

// ==== Makefile ====
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f files.f --top-module mem_io_tb \
		-Mdir $(OBJ_DIR) -o mem_io_sim

run: compile
	@out="$$(./$(OBJ_DIR)/mem_io_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
